//--- source/mips_types_pkg.sv
//==========================================================================
// MIPS32 integer subset: widths, field types and instruction encodings
// Byte addresses throughout, word aligned accesses only
//==========================================================================
package mips_types_pkg;

	// Data path and field widths
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [15:0] imm_t;

	// Primary opcodes, bits 31:26
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;

	// SPECIAL function field, bits 5:0
	localparam logic [5:0] FN_ADDU  = 6'h21;
	localparam logic [5:0] FN_SUBU  = 6'h23;
	localparam logic [5:0] FN_AND   = 6'h24;
	localparam logic [5:0] FN_OR    = 6'h25;
	localparam logic [5:0] FN_SLT   = 6'h2a;
	localparam logic [5:0] FN_BREAK = 6'h0d;

	// ALU operation select
	typedef logic [2:0] alu_op_t;
	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR  = 3'd3;
	localparam alu_op_t ALU_SLT = 3'd4;

	// Execute operand source
	typedef logic [1:0] fwd_sel_t;
	localparam fwd_sel_t FWD_REG = 2'd0;
	localparam fwd_sel_t FWD_MEM = 2'd1;
	localparam fwd_sel_t FWD_WB  = 2'd2;

	localparam addr_t RESET_PC = 32'h0000_0000;

endpackage

//--- source/pipeline_pkg.sv
//==========================================================================
// Records carried between pipeline stages and the hazard control record
// Every record is qualified by its valid bit, other fields are don't-care
//==========================================================================
package pipeline_pkg;

	import mips_types_pkg::*;

	// Decode output
	typedef struct packed {
		logic      valid;
		logic      uses_rs;
		logic      uses_rt;
		logic      uses_imm;
		logic      is_load;
		logic      is_store;
		logic      is_branch_eq;
		logic      is_branch_ne;
		logic      writes_rd;
		logic      is_break;
		alu_op_t   alu_op;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
		// Sign-extended immediate
		word_t     imm;
	} decoded_t;

	typedef struct packed {
		logic  valid;
		addr_t pc;
		word_t instr;
	} if_id_t;

	// Valid lives in dec
	typedef struct packed {
		decoded_t dec;
		addr_t    pc;
		word_t    rs_data;
		word_t    rt_data;
	} id_ex_t;

	typedef struct packed {
		logic      valid;
		logic      is_load;
		logic      is_store;
		logic      writes_rd;
		logic      is_break;
		reg_addr_t dest;
		word_t     result;
		word_t     store_data;
	} ex_mem_t;

	typedef struct packed {
		logic      valid;
		logic      writes_rd;
		logic      is_break;
		reg_addr_t dest;
		word_t     result;
	} mem_wb_t;

	// Flush outranks stall
	typedef struct packed {
		logic stall;
		logic flush;
	} stage_ctl_t;

	typedef struct packed {
		stage_ctl_t pc;
		stage_ctl_t if_id;
		stage_ctl_t id_ex;
		stage_ctl_t ex_mem;
		stage_ctl_t mem_wb;
	} hazard_ctl_t;

	typedef struct packed {
		logic  taken;
		addr_t target;
	} branch_result_t;

endpackage

//--- source/fetch_unit.sv
//==========================================================================
// Program counter, starts at RESET_PC
// A taken branch wins over a stall
//==========================================================================
`timescale 1ns/1ps

module fetch_unit (
	input  logic                         clk,
	input  logic                         i_reset,
	input  logic                         i_stall,
	input  pipeline_pkg::branch_result_t i_branch,
	output mips_types_pkg::addr_t        o_pc
);

	import mips_types_pkg::*;

	addr_t pc_r;

	always_ff @(posedge clk)
	begin
		if (i_reset)
			pc_r <= RESET_PC;
		// Redirect from execute, wrong-path fetches get flushed
		else if (i_branch.taken)
			pc_r <= i_branch.target;
		// Load-use hold
		else if (!i_stall)
			pc_r <= pc_r + 32'd4;
	end

	// Drives the instruction port directly
	assign o_pc = pc_r;

endmodule

//--- source/decoder.sv
//==========================================================================
// Decode of the supported subset only
// Anything else becomes a bubble, no exception is raised
//==========================================================================
`timescale 1ns/1ps

module decoder (
	input  pipeline_pkg::if_id_t   i_fetch,
	output pipeline_pkg::decoded_t o_decoded
);

	import mips_types_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	imm_t       imm;
	reg_addr_t  rd;

	// Instruction fields
	assign opcode = i_fetch.instr[31:26];
	assign funct  = i_fetch.instr[5:0];
	assign imm    = i_fetch.instr[15:0];
	assign rd     = i_fetch.instr[15:11];

	always_comb
	begin
		// Start from a bubble reading nothing
		o_decoded        = '0;
		o_decoded.rs     = i_fetch.instr[25:21];
		o_decoded.rt     = i_fetch.instr[20:16];
		o_decoded.imm    = {{16{imm[15]}}, imm};
		o_decoded.alu_op = ALU_ADD;

		case (opcode)
			OP_SPECIAL:
			begin
				if (funct == FN_BREAK)
				begin
					o_decoded.is_break = 1'b1;
					o_decoded.valid    = 1'b1;
				end
				else
				begin
					// R-type, rd is the target
					o_decoded.uses_rs   = 1'b1;
					o_decoded.uses_rt   = 1'b1;
					o_decoded.writes_rd = 1'b1;
					o_decoded.dest      = rd;
					o_decoded.valid     = 1'b1;
					case (funct)
						FN_ADDU: o_decoded.alu_op = ALU_ADD;
						FN_SUBU: o_decoded.alu_op = ALU_SUB;
						FN_AND:  o_decoded.alu_op = ALU_AND;
						FN_OR:   o_decoded.alu_op = ALU_OR;
						FN_SLT:  o_decoded.alu_op = ALU_SLT;
						default: o_decoded.valid  = 1'b0;
					endcase
				end
			end
			OP_ADDIU, OP_LW:
			begin
				// I-type writes rt
				o_decoded.uses_rs   = 1'b1;
				o_decoded.uses_imm  = 1'b1;
				o_decoded.is_load   = (opcode == OP_LW);
				o_decoded.writes_rd = 1'b1;
				o_decoded.dest      = o_decoded.rt;
				o_decoded.valid     = 1'b1;
			end
			OP_SW:
			begin
				// rt is the store data
				o_decoded.uses_rs  = 1'b1;
				o_decoded.uses_rt  = 1'b1;
				o_decoded.uses_imm = 1'b1;
				o_decoded.is_store = 1'b1;
				o_decoded.valid    = 1'b1;
			end
			OP_BEQ, OP_BNE:
			begin
				o_decoded.uses_rs      = 1'b1;
				o_decoded.uses_rt      = 1'b1;
				o_decoded.is_branch_eq = (opcode == OP_BEQ);
				o_decoded.is_branch_ne = (opcode == OP_BNE);
				o_decoded.alu_op       = ALU_SUB;
				o_decoded.valid        = 1'b1;
			end
			default: o_decoded.valid = 1'b0;
		endcase

		// Empty fetch slot stays a bubble
		o_decoded.valid = o_decoded.valid && i_fetch.valid;
	end

endmodule

//--- source/reg_file.sv
//==========================================================================
// 32 x 32 register file, two combinational reads, one write
// r0 reads zero, a same-cycle write is visible to the reads
//==========================================================================
`timescale 1ns/1ps

module reg_file (
	input  logic                      clk,
	input  logic                      i_reset,
	input  mips_types_pkg::reg_addr_t i_rs_addr,
	input  mips_types_pkg::reg_addr_t i_rt_addr,
	input  pipeline_pkg::mem_wb_t     i_wb,
	output mips_types_pkg::word_t     o_rs_data,
	output mips_types_pkg::word_t     o_rt_data
);

	import mips_types_pkg::*;

	word_t regs [0:31];
	logic  we;

	// Read port with write-through from write-back
	function automatic word_t read_port(
		input reg_addr_t addr,
		input word_t     stored,
		input logic      wr_en,
		input reg_addr_t wr_addr,
		input word_t     wr_data
	);
		if (addr == 5'd0)
			return '0;
		else if (wr_en && (wr_addr == addr))
			return wr_data;
		else
			return stored;
	endfunction

	// No write while reset is held, r0 never written
	assign we = !i_reset && i_wb.valid && i_wb.writes_rd && (i_wb.dest != 5'd0);

	always_ff @(posedge clk)
	begin
		if (we)
			regs[i_wb.dest] <= i_wb.result;
	end

	assign o_rs_data = read_port(i_rs_addr, regs[i_rs_addr], we, i_wb.dest, i_wb.result);
	assign o_rt_data = read_port(i_rt_addr, regs[i_rt_addr], we, i_wb.dest, i_wb.result);

endmodule

//--- source/forward_unit.sv
//==========================================================================
// Operand bypass select for execute, plus load-use detection for decode
// Memory stage beats write-back, r0 is never bypassed
//==========================================================================
`timescale 1ns/1ps

module forward_unit (
	input  pipeline_pkg::decoded_t   i_decoded,
	input  pipeline_pkg::id_ex_t     i_id_ex,
	input  pipeline_pkg::ex_mem_t    i_ex_mem,
	input  pipeline_pkg::mem_wb_t    i_mem_wb,
	output mips_types_pkg::fwd_sel_t o_fwd_a,
	output mips_types_pkg::fwd_sel_t o_fwd_b,
	output logic                     o_load_use
);

	import mips_types_pkg::*;

	reg_addr_t mem_dest;
	reg_addr_t wb_dest;
	reg_addr_t ex_dest;

	function automatic fwd_sel_t pick_source(
		input logic      uses,
		input reg_addr_t src,
		input reg_addr_t mem_d,
		input reg_addr_t wb_d
	);
		if (!uses || (src == 5'd0))
			return FWD_REG;
		// Younger producer first
		else if (src == mem_d)
			return FWD_MEM;
		else if (src == wb_d)
			return FWD_WB;
		else
			return FWD_REG;
	endfunction

	// Non-writing stages show up as r0, which never matches
	assign mem_dest = (i_ex_mem.valid && i_ex_mem.writes_rd) ? i_ex_mem.dest : 5'd0;
	assign wb_dest  = (i_mem_wb.valid && i_mem_wb.writes_rd) ? i_mem_wb.dest : 5'd0;

	assign o_fwd_a = pick_source(i_id_ex.dec.uses_rs, i_id_ex.dec.rs, mem_dest, wb_dest);
	assign o_fwd_b = pick_source(i_id_ex.dec.uses_rt, i_id_ex.dec.rt, mem_dest, wb_dest);

	// Load in execute, its data exists only one stage later
	assign ex_dest = (i_id_ex.dec.valid && i_id_ex.dec.is_load) ? i_id_ex.dec.dest : 5'd0;

	assign o_load_use = i_decoded.valid && (ex_dest != 5'd0)
		&& ((i_decoded.uses_rs && (i_decoded.rs == ex_dest))
		|| (i_decoded.uses_rt && (i_decoded.rt == ex_dest)));

endmodule

//--- source/alu.sv
//==========================================================================
// Execute stage: operand bypass mux, ALU and branch resolution
// Branch target is pc + 4 + (imm << 2), no delay slot
//==========================================================================
`timescale 1ns/1ps

module alu (
	input  pipeline_pkg::id_ex_t         i_id_ex,
	input  mips_types_pkg::fwd_sel_t     i_fwd_a,
	input  mips_types_pkg::fwd_sel_t     i_fwd_b,
	input  mips_types_pkg::word_t        i_mem_result,
	input  mips_types_pkg::word_t        i_wb_result,
	output mips_types_pkg::word_t        o_result,
	output mips_types_pkg::word_t        o_store_data,
	output pipeline_pkg::branch_result_t o_branch
);

	import mips_types_pkg::*;

	word_t rs_val;
	word_t rt_val;
	word_t op_b;

	function automatic word_t select_operand(
		input fwd_sel_t sel,
		input word_t    reg_val,
		input word_t    mem_val,
		input word_t    wb_val
	);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign rs_val = select_operand(i_fwd_a, i_id_ex.rs_data, i_mem_result, i_wb_result);
	assign rt_val = select_operand(i_fwd_b, i_id_ex.rt_data, i_mem_result, i_wb_result);

	// ADDIU, LW and SW take the immediate
	assign op_b = i_id_ex.dec.uses_imm ? i_id_ex.dec.imm : rt_val;

	always_comb
	begin
		case (i_id_ex.dec.alu_op)
			ALU_SUB: o_result = rs_val - op_b;
			ALU_AND: o_result = rs_val & op_b;
			ALU_OR:  o_result = rs_val | op_b;
			// Signed compare
			ALU_SLT: o_result = {31'd0, $signed(rs_val) < $signed(op_b)};
			default: o_result = rs_val + op_b;
		endcase
	end

	// Store data after bypass
	assign o_store_data = rt_val;

	assign o_branch.target = i_id_ex.pc + 32'd4 + {i_id_ex.dec.imm[29:0], 2'b00};
	assign o_branch.taken  = i_id_ex.dec.valid
		&& ((i_id_ex.dec.is_branch_eq && (rs_val == rt_val))
		|| (i_id_ex.dec.is_branch_ne && (rs_val != rt_val)));

endmodule

//--- source/hazard_controller.sv
//==========================================================================
// Stall and flush for each pipeline register
// Branch flush wins over the load-use stall
//==========================================================================
`timescale 1ns/1ps

module hazard_controller (
	input  logic                         i_load_use,
	input  pipeline_pkg::branch_result_t i_branch,
	output pipeline_pkg::hazard_ctl_t    o_hc
);

	always_comb
	begin
		// Memory and write-back always advance
		o_hc = '0;

		if (i_branch.taken)
		begin
			// Kill the two wrong-path instructions
			o_hc.if_id.flush = 1'b1;
			o_hc.id_ex.flush = 1'b1;
		end
		else if (i_load_use)
		begin
			// Hold fetch and decode, bubble into execute
			o_hc.pc.stall    = 1'b1;
			o_hc.if_id.stall = 1'b1;
			o_hc.id_ex.flush = 1'b1;
		end
	end

endmodule

//--- source/mips_core.sv
//==========================================================================
// Five-stage MIPS32 subset core, in-order, single issue
// Instruction and data ports answer combinationally, no wait states
// o_done is sticky until reset, nothing after BREAK is committed
//==========================================================================
`timescale 1ns/1ps

module mips_core (
	input  logic                  clk,
	input  logic                  i_reset,
	output mips_types_pkg::addr_t o_imem_addr,
	input  mips_types_pkg::word_t i_imem_data,
	output mips_types_pkg::addr_t o_dmem_addr,
	output mips_types_pkg::word_t o_dmem_wdata,
	output logic                  o_dmem_we,
	output logic                  o_dmem_re,
	input  mips_types_pkg::word_t i_dmem_rdata,
	output logic                  o_done
);

	import mips_types_pkg::*;
	import pipeline_pkg::*;

	addr_t          pc;
	if_id_t         if_id;
	decoded_t       decoded;
	word_t          rs_data;
	word_t          rt_data;
	id_ex_t         id_ex;
	fwd_sel_t       fwd_a;
	fwd_sel_t       fwd_b;
	logic           load_use;
	word_t          alu_result;
	word_t          store_data;
	branch_result_t branch;
	ex_mem_t        ex_mem;
	word_t          mem_result;
	mem_wb_t        mem_wb;
	hazard_ctl_t    hc;
	logic           draining;
	logic           done_r;

	//==========================================================================
	// Fetch
	//==========================================================================
	fetch_unit fetch_unit_i (
		.clk      (clk),
		.i_reset  (i_reset),
		.i_stall  (hc.pc.stall),
		.i_branch (branch),
		.o_pc     (pc)
	);

	assign o_imem_addr = pc;

	always_ff @(posedge clk)
	begin
		if (i_reset || hc.if_id.flush)
			if_id.valid <= 1'b0;
		else if (!hc.if_id.stall)
		begin
			if_id.valid <= 1'b1;
			if_id.pc    <= pc;
			if_id.instr <= i_imem_data;
		end
	end

	//==========================================================================
	// Decode
	//==========================================================================
	decoder decoder_i (
		.i_fetch   (if_id),
		.o_decoded (decoded)
	);

	reg_file reg_file_i (
		.clk       (clk),
		.i_reset   (i_reset),
		.i_rs_addr (decoded.rs),
		.i_rt_addr (decoded.rt),
		.i_wb      (mem_wb),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data)
	);

	always_ff @(posedge clk)
	begin
		if (i_reset || hc.id_ex.flush)
			id_ex.dec.valid <= 1'b0;
		else if (!hc.id_ex.stall)
		begin
			id_ex.dec     <= decoded;
			id_ex.pc      <= if_id.pc;
			id_ex.rs_data <= rs_data;
			id_ex.rt_data <= rt_data;
		end
	end

	//==========================================================================
	// Execute
	//==========================================================================
	forward_unit forward_unit_i (
		.i_decoded  (decoded),
		.i_id_ex    (id_ex),
		.i_ex_mem   (ex_mem),
		.i_mem_wb   (mem_wb),
		.o_fwd_a    (fwd_a),
		.o_fwd_b    (fwd_b),
		.o_load_use (load_use)
	);

	alu alu_i (
		.i_id_ex      (id_ex),
		.i_fwd_a      (fwd_a),
		.i_fwd_b      (fwd_b),
		.i_mem_result (mem_result),
		.i_wb_result  (mem_wb.result),
		.o_result     (alu_result),
		.o_store_data (store_data),
		.o_branch     (branch)
	);

	// BREAK ahead in memory or write-back, younger work is dropped here
	assign draining = (ex_mem.valid && ex_mem.is_break)
		|| (mem_wb.valid && mem_wb.is_break) || done_r;

	always_ff @(posedge clk)
	begin
		if (i_reset || hc.ex_mem.flush)
			ex_mem.valid <= 1'b0;
		else if (!hc.ex_mem.stall)
		begin
			ex_mem.valid      <= id_ex.dec.valid && !draining;
			ex_mem.is_load    <= id_ex.dec.is_load;
			ex_mem.is_store   <= id_ex.dec.is_store;
			ex_mem.writes_rd  <= id_ex.dec.writes_rd;
			ex_mem.is_break   <= id_ex.dec.is_break;
			ex_mem.dest       <= id_ex.dec.dest;
			ex_mem.result     <= alu_result;
			ex_mem.store_data <= store_data;
		end
	end

	//==========================================================================
	// Memory
	//==========================================================================
	// Strobes only for live entries
	assign o_dmem_addr  = ex_mem.result;
	assign o_dmem_wdata = ex_mem.store_data;
	assign o_dmem_we    = ex_mem.valid && ex_mem.is_store;
	assign o_dmem_re    = ex_mem.valid && ex_mem.is_load;

	// Also the memory-stage bypass value
	assign mem_result = ex_mem.is_load ? i_dmem_rdata : ex_mem.result;

	always_ff @(posedge clk)
	begin
		if (i_reset || hc.mem_wb.flush)
			mem_wb.valid <= 1'b0;
		else if (!hc.mem_wb.stall)
		begin
			mem_wb.valid     <= ex_mem.valid;
			mem_wb.writes_rd <= ex_mem.writes_rd;
			mem_wb.is_break  <= ex_mem.is_break;
			mem_wb.dest      <= ex_mem.dest;
			mem_wb.result    <= mem_result;
		end
	end

	//==========================================================================
	// Write-back and hazard control
	//==========================================================================
	// Register write happens inside reg_file
	always_ff @(posedge clk)
	begin
		if (i_reset)
			done_r <= 1'b0;
		else if (mem_wb.valid && mem_wb.is_break)
			done_r <= 1'b1;
	end

	assign o_done = done_r;

	hazard_controller hazard_controller_i (
		.i_load_use (load_use),
		.i_branch   (branch),
		.o_hc       (hc)
	);

endmodule

//--- testbench/mips_core_assertions.sv
//==========================================================================
// Concurrent checks on the data port strobes and the done flag
// Bound into mips_core, error_count holds the number of failed checks
//==========================================================================
`timescale 1ns/1ps

module mips_core_assertions (
	input logic clk,
	input logic i_reset,
	input logic i_dmem_we,
	input logic i_dmem_re,
	input logic i_done
);

	int error_count = 0;

	// Read and write never share a cycle
	strobes_exclusive: assert property (@(posedge clk) disable iff (i_reset)
		!(i_dmem_we && i_dmem_re))
	else
	begin
		$error("data port read and write strobes high in the same cycle");
		error_count++;
	end

	// Sticky until reset
	done_sticky: assert property (@(posedge clk) (i_done && !i_reset) |=> i_done)
	else
	begin
		$error("o_done fell without reset");
		error_count++;
	end

	// Memory quiet right after a reset cycle
	reset_quiet: assert property (@(posedge clk) i_reset |=> (!i_dmem_we && !i_dmem_re))
	else
	begin
		$error("data port strobe high in the cycle after reset");
		error_count++;
	end

endmodule

//--- testbench/mips_core_tb.sv
//==========================================================================
// Directed testbench for mips_core with combinational memory models
// Data port traffic is sampled on the falling edge, one entry per strobe
// Unused instruction words hold BREAK, so a runaway program still stops
//==========================================================================
`timescale 1ns/1ps

module mips_core_tb;

	import mips_types_pkg::*;

	localparam int TIMEOUT_CYCLES = 1000;

	logic   clk;
	logic   i_reset;
	addr_t  o_imem_addr;
	word_t  i_imem_data;
	addr_t  o_dmem_addr;
	word_t  o_dmem_wdata;
	logic   o_dmem_we;
	logic   o_dmem_re;
	word_t  i_dmem_rdata;
	logic   o_done;
	integer seed;

	word_t imem [0:255];
	word_t dmem [0:511];
	word_t program_q [$];
	addr_t store_addr_q [$];
	word_t store_data_q [$];
	addr_t load_addr_q [$];
	addr_t exp_addr_q [$];
	word_t exp_data_q [$];
	addr_t exp_load_q [$];

	mips_core dut_i (
		.clk          (clk),
		.i_reset      (i_reset),
		.o_imem_addr  (o_imem_addr),
		.i_imem_data  (i_imem_data),
		.o_dmem_addr  (o_dmem_addr),
		.o_dmem_wdata (o_dmem_wdata),
		.o_dmem_we    (o_dmem_we),
		.o_dmem_re    (o_dmem_re),
		.i_dmem_rdata (i_dmem_rdata),
		.o_done       (o_done)
	);

	bind mips_core mips_core_assertions assertions_i (
		.clk       (clk),
		.i_reset   (i_reset),
		.i_dmem_we (o_dmem_we),
		.i_dmem_re (o_dmem_re),
		.i_done    (o_done)
	);

	initial
		clk = 1'b0;
	always #2 clk = ~clk;

	//==========================================================================
	// Memory models
	//==========================================================================
	assign i_imem_data  = imem[o_imem_addr[9:2]];
	assign i_dmem_rdata = dmem[o_dmem_addr[10:2]];

	// Store and load log, strobes are stable mid-cycle
	always @(negedge clk)
	begin
		if (o_dmem_we)
		begin
			store_addr_q.push_back(o_dmem_addr);
			store_data_q.push_back(o_dmem_wdata);
			dmem[o_dmem_addr[10:2]] = o_dmem_wdata;
		end
		if (o_dmem_re)
			load_addr_q.push_back(o_dmem_addr);
	end

	//==========================================================================
	// Instruction encoders
	//==========================================================================
	function automatic word_t r_instr(input logic [5:0] fn, input reg_addr_t rd,
		input reg_addr_t rs, input reg_addr_t rt);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t i_instr(input logic [5:0] op, input reg_addr_t rt,
		input reg_addr_t rs, input imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	// Code field carries a tag
	function automatic word_t break_instr(input logic [19:0] code);
		return {OP_SPECIAL, code, FN_BREAK};
	endfunction

	function automatic word_t sign_extend(input imm_t imm);
		return {{16{imm[15]}}, imm};
	endfunction

	//==========================================================================
	// Helpers
	//==========================================================================
	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h",
				name, got, exp));
	endtask

	task automatic fill_memories();
		// BREAK everywhere, tagged with the word index
		for (int i = 0; i < 256; i++)
			imem[i] = break_instr(20'(i));
		// Data pattern follows the full word address
		for (int i = 0; i < 512; i++)
			dmem[i] = word_t'(i) * 32'h9e37_79b9;
	endtask

	task automatic start_test(input string name);
		$display("Test: %s", name);
		program_q.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
		exp_load_q.delete();
	endtask

	task automatic emit(input word_t w);
		program_q.push_back(w);
	endtask

	task automatic expect_store(input addr_t addr, input word_t data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	task automatic expect_load(input addr_t addr);
		exp_load_q.push_back(addr);
	endtask

	// Reset, load, run until o_done, then let the pipeline drain
	task automatic run_program();
		int cycles;
		@(negedge clk);
		i_reset = 1'b1;
		fill_memories();
		for (int i = 0; i < program_q.size(); i++)
			imem[i] = program_q[i];
		repeat (5) @(negedge clk);
		store_addr_q.delete();
		store_data_q.delete();
		load_addr_q.delete();
		i_reset = 1'b0;
		cycles = 0;
		while (o_done !== 1'b1)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				stop_with_failure("Timeout: o_done did not rise after BREAK");
		end
		// Anything queued behind BREAK would show up here
		repeat (8) @(negedge clk);
		check_value("o_done", word_t'(o_done), 32'd1);
	endtask

	task automatic compare_stores();
		check_value("store count", store_addr_q.size(), exp_addr_q.size());
		for (int i = 0; i < exp_addr_q.size(); i++)
		begin
			check_value("o_dmem_addr", store_addr_q[i], exp_addr_q[i]);
			check_value("o_dmem_wdata", store_data_q[i], exp_data_q[i]);
		end
	endtask

	// One o_dmem_re cycle per LW, none otherwise
	task automatic compare_loads();
		check_value("o_dmem_re count", load_addr_q.size(), exp_load_q.size());
		for (int i = 0; i < exp_load_q.size(); i++)
			check_value("o_dmem_addr on load", load_addr_q[i], exp_load_q[i]);
	endtask

	//==========================================================================
	// Directed tests
	//==========================================================================
	// Back-to-back producers, bypass from memory and write-back
	task automatic alu_chain();
		word_t r1, r2, r3, r4, r5, r6, r7, r8;
		start_test("dependent R-type chain");
		r1 = sign_extend(16'h7fff);
		r2 = sign_extend(16'h8003);
		r3 = r1 + r2;
		r4 = r1 - r3;
		r5 = r4 & r2;
		r6 = r5 | r3;
		r7 = ($signed(r2) < $signed(r6)) ? 32'd1 : 32'd0;
		r8 = ($signed(r6) < $signed(r2)) ? 32'd1 : 32'd0;
		emit(i_instr(OP_ADDIU, 1, 0, 16'h7fff));
		emit(i_instr(OP_ADDIU, 2, 0, 16'h8003));
		emit(r_instr(FN_ADDU, 3, 1, 2));
		emit(r_instr(FN_SUBU, 4, 1, 3));
		emit(r_instr(FN_AND, 5, 4, 2));
		emit(r_instr(FN_OR, 6, 5, 3));
		emit(r_instr(FN_SLT, 7, 2, 6));
		emit(r_instr(FN_SLT, 8, 6, 2));
		emit(i_instr(OP_SW, 8, 0, 16'h0014));
		emit(i_instr(OP_SW, 7, 0, 16'h0010));
		emit(i_instr(OP_SW, 6, 0, 16'h000c));
		emit(i_instr(OP_SW, 5, 0, 16'h0008));
		emit(i_instr(OP_SW, 4, 0, 16'h0004));
		emit(i_instr(OP_SW, 3, 0, 16'h0000));
		emit(break_instr(20'h1));
		expect_store(32'h14, r8);
		expect_store(32'h10, r7);
		expect_store(32'h0c, r6);
		expect_store(32'h08, r5);
		expect_store(32'h04, r4);
		expect_store(32'h00, r3);
		run_program();
		compare_stores();
		compare_loads();
	endtask

	// LW result used by the very next instruction
	task automatic load_use_stall();
		start_test("load-use stall");
		emit(i_instr(OP_ADDIU, 1, 0, 16'h1234));
		emit(i_instr(OP_ADDIU, 2, 0, 16'h0111));
		emit(i_instr(OP_SW, 1, 0, 16'h0040));
		emit(i_instr(OP_LW, 3, 0, 16'h0040));
		emit(r_instr(FN_ADDU, 4, 3, 2));
		emit(i_instr(OP_SW, 4, 0, 16'h0044));
		emit(break_instr(20'h2));
		expect_store(32'h40, 32'h1234);
		expect_store(32'h44, 32'h1234 + 32'h0111);
		expect_load(32'h40);
		run_program();
		compare_stores();
		compare_loads();
	endtask

	task automatic branch_skip();
		start_test("taken and not-taken branches");
		emit(i_instr(OP_ADDIU, 1, 0, 16'd5));
		emit(i_instr(OP_ADDIU, 2, 0, 16'd5));
		// Equal, skips the next two words
		emit(i_instr(OP_BEQ, 2, 1, 16'd2));
		emit(i_instr(OP_SW, 1, 0, 16'h0080));
		emit(i_instr(OP_SW, 2, 0, 16'h0084));
		emit(i_instr(OP_ADDIU, 3, 0, 16'd7));
		// Equal, falls through
		emit(i_instr(OP_BNE, 2, 1, 16'd1));
		emit(i_instr(OP_SW, 3, 0, 16'h0088));
		emit(i_instr(OP_BNE, 3, 1, 16'd1));
		emit(i_instr(OP_SW, 1, 0, 16'h008c));
		emit(i_instr(OP_SW, 3, 0, 16'h0090));
		emit(break_instr(20'h3));
		expect_store(32'h88, 32'd7);
		expect_store(32'h90, 32'd7);
		run_program();
		compare_stores();
		compare_loads();
	endtask

	task automatic zero_register();
		start_test("register zero");
		emit(i_instr(OP_ADDIU, 0, 0, 16'h0055));
		emit(i_instr(OP_SW, 0, 0, 16'h00c0));
		emit(i_instr(OP_ADDIU, 0, 0, 16'h0066));
		emit(r_instr(FN_ADDU, 9, 0, 0));
		emit(i_instr(OP_SW, 9, 0, 16'h00c4));
		emit(break_instr(20'h4));
		expect_store(32'hc0, 32'd0);
		expect_store(32'hc4, 32'd0);
		run_program();
		compare_stores();
		compare_loads();
	endtask

	// Running sum in r11, each step stored
	task automatic random_sum();
		imm_t  imm;
		word_t sum;
		start_test("random ADDIU/ADDU sum");
		sum = '0;
		emit(i_instr(OP_ADDIU, 11, 0, 16'h0000));
		for (int i = 0; i < 20; i++)
		begin
			imm = imm_t'($random(seed));
			sum = sum + sign_extend(imm);
			emit(i_instr(OP_ADDIU, 10, 0, imm));
			emit(r_instr(FN_ADDU, 11, 11, 10));
			emit(i_instr(OP_SW, 11, 0, imm_t'(16'h0100 + 4 * i)));
			expect_store(addr_t'(32'h100 + 4 * i), sum);
		end
		emit(break_instr(20'h5));
		run_program();
		compare_stores();
		compare_loads();
	endtask

	task automatic break_termination();
		start_test("termination at BREAK");
		emit(i_instr(OP_ADDIU, 1, 0, 16'h002a));
		emit(i_instr(OP_SW, 1, 0, 16'h0200));
		emit(break_instr(20'h6));
		// Nothing below may commit
		emit(i_instr(OP_SW, 1, 0, 16'h0204));
		emit(i_instr(OP_SW, 1, 0, 16'h0208));
		emit(i_instr(OP_ADDIU, 1, 0, 16'h0001));
		emit(i_instr(OP_SW, 1, 0, 16'h020c));
		expect_store(32'h200, 32'h2a);
		run_program();
		compare_stores();
		compare_loads();
	endtask

	//==========================================================================
	// Sequence
	//==========================================================================
	initial
	begin
		seed = 32'h6cd145d6;
		i_reset = 1'b1;
		fill_memories();
		alu_chain();
		load_use_stall();
		branch_skip();
		zero_register();
		random_sum();
		break_termination();
		if (dut_i.assertions_i.error_count != 0)
			stop_with_failure($sformatf("%0d assertion failures in the bound checker",
				dut_i.assertions_i.error_count));
		else
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

//--- tb.f
source/mips_types_pkg.sv
source/pipeline_pkg.sv
source/fetch_unit.sv
source/decoder.sv
source/reg_file.sv
source/forward_unit.sv
source/alu.sv
source/hazard_controller.sv
source/mips_core.sv
testbench/mips_core_assertions.sv
testbench/mips_core_tb.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - source/mips_types_pkg.sv
  - source/pipeline_pkg.sv
  - source/fetch_unit.sv
  - source/decoder.sv
  - source/reg_file.sv
  - source/forward_unit.sv
  - source/alu.sv
  - source/hazard_controller.sv
  - source/mips_core.sv
  - target: test
    files:
      - testbench/mips_core_assertions.sv
      - testbench/mips_core_tb.sv
